/* hdl/act_cfg_if.sv */
`timescale 1ns/10ps

interface act_cfg_if;
	import conv_act_pkg::*;

	logic act_en;
	data_t act_rate_c; // leaky slope
	logic par_wen; // single cycle strobe
	par_sel_e par_sel;
	chn_t par_chn;
	data_t par_data;

	modport regs (
		output act_en, act_rate_c,
		output par_wen, par_sel, par_chn, par_data
	);

	modport cal (
		input act_en, act_rate_c,
		input par_wen, par_sel, par_chn, par_data
	);
endinterface

/* hdl/conv_act_cfg.svh */
`ifndef CONV_ACT_CFG_SVH
`define CONV_ACT_CFG_SVH

// feature and coefficient width
`define DATA_W 16

// fixed point positions
`define X_FRAC 10 // x, b and the result
`define AB_FRAC 12 // coefficient a
`define C_FRAC 14 // leaky slope c

// output channels that own an a/b pair
`define CHN_N 16
`define CHN_W 4

// register space
`define AXIL_AW 12

`endif

/* hdl/conv_act_pkg.sv */
`include "conv_act_cfg.svh"

package conv_act_pkg;

	typedef logic signed [`DATA_W-1:0] data_t; // feature or coefficient
	typedef logic [`CHN_W-1:0] chn_t;

	// target array of a parameter write
	typedef enum logic {
		PAR_A,
		PAR_B
	} par_sel_e;

	// register word addresses
	typedef enum logic [`AXIL_AW-1:0] {
		REG_CTRL = 'h000, // bit0 act_en, bit1 itr_en
		REG_STATUS = 'h004, // bit0 pending, write 1 to clear
		REG_ACT_C = 'h008,
		REG_ITR_TH = 'h00C,
		REG_RES_CNT = 'h010,
		REG_PAR_A_BASE = 'h100, // one word per channel
		REG_PAR_B_BASE = 'h200
	} reg_addr_e;

	typedef enum logic {
		AXIL_IDLE,
		AXIL_RESP
	} axil_state_e;

endpackage

/* hdl/conv_act_regs.sv */
`timescale 1ns/10ps
`include "conv_act_cfg.svh"

module conv_act_regs (
	input logic clk,
	input logic rst_n,

	input logic [`AXIL_AW-1:0] s_axi_lite_awaddr,
	input logic s_axi_lite_awvalid,
	output logic s_axi_lite_awready,
	input logic [31:0] s_axi_lite_wdata,
	input logic [3:0] s_axi_lite_wstrb, // not decoded
	input logic s_axi_lite_wvalid,
	output logic s_axi_lite_wready,
	output logic [1:0] s_axi_lite_bresp,
	output logic s_axi_lite_bvalid,
	input logic s_axi_lite_bready,
	input logic [`AXIL_AW-1:0] s_axi_lite_araddr,
	input logic s_axi_lite_arvalid,
	output logic s_axi_lite_arready,
	output logic [31:0] s_axi_lite_rdata,
	output logic [1:0] s_axi_lite_rresp,
	output logic s_axi_lite_rvalid,
	input logic s_axi_lite_rready,

	act_cfg_if.regs cfg,
	input logic res_fire,
	output logic itr
);
	import conv_act_pkg::*;

	axil_state_e w_state;
	axil_state_e r_state;
	logic aw_w_rdy;
	logic wr_en;
	logic [`AXIL_AW-1:0] wr_page;
	logic par_win;
	logic act_en;
	logic itr_en;
	logic itr_pend;
	data_t act_rate_c;
	logic [31:0] itr_th;
	logic [31:0] res_cnt;
	logic [31:0] res_cnt_inc;
	logic [31:0] rd_mux;

	assign s_axi_lite_awready = aw_w_rdy;
	assign s_axi_lite_wready = aw_w_rdy;
	assign s_axi_lite_bresp = 2'b00; // always OKAY
	assign s_axi_lite_rresp = 2'b00;
	assign s_axi_lite_arready = (r_state == AXIL_IDLE);
	assign wr_en = aw_w_rdy && s_axi_lite_awvalid && s_axi_lite_wvalid;

	// a/b windows, channel index in the word offset
	assign wr_page = {s_axi_lite_awaddr[`AXIL_AW-1:8], 8'h00};
	assign par_win = (wr_page == REG_PAR_A_BASE || wr_page == REG_PAR_B_BASE) &&
		(s_axi_lite_awaddr[7:`CHN_W+2] == '0);

	// address and data taken together, one beat per write
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			w_state <= AXIL_IDLE;
			aw_w_rdy <= 1'b0;
			s_axi_lite_bvalid <= 1'b0;
		end else begin
			case (w_state)
				AXIL_IDLE: begin
					if (aw_w_rdy) begin
						aw_w_rdy <= 1'b0;
						s_axi_lite_bvalid <= 1'b1;
						w_state <= AXIL_RESP;
					end else if (s_axi_lite_awvalid && s_axi_lite_wvalid) begin
						aw_w_rdy <= 1'b1;
					end
				end
				AXIL_RESP: begin
					if (s_axi_lite_bready) begin
						s_axi_lite_bvalid <= 1'b0;
						w_state <= AXIL_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			act_en <= 1'b0;
			itr_en <= 1'b0;
			act_rate_c <= '0;
			itr_th <= '0;
		end else if (wr_en) begin
			case (s_axi_lite_awaddr)
				REG_CTRL: begin
					act_en <= s_axi_lite_wdata[0];
					itr_en <= s_axi_lite_wdata[1];
				end
				REG_ACT_C: act_rate_c <= s_axi_lite_wdata[`DATA_W-1:0];
				REG_ITR_TH: itr_th <= s_axi_lite_wdata;
				default: ;
			endcase
		end
	end

	assign cfg.act_en = act_en;
	assign cfg.act_rate_c = act_rate_c;

	// parameter write strobe
	always_ff @(posedge clk) begin
		if (!rst_n)
			cfg.par_wen <= 1'b0;
		else
			cfg.par_wen <= wr_en && par_win;
	end

	always_ff @(posedge clk) begin
		if (wr_en && par_win) begin
			cfg.par_sel <= (wr_page == REG_PAR_B_BASE) ? PAR_B : PAR_A;
			cfg.par_chn <= s_axi_lite_awaddr[`CHN_W+1:2];
			cfg.par_data <= s_axi_lite_wdata[`DATA_W-1:0];
		end
	end

	assign res_cnt_inc = res_cnt + 32'd1;

	// result counter and sticky interrupt
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			res_cnt <= '0;
			itr_pend <= 1'b0;
		end else begin
			if (wr_en && s_axi_lite_awaddr == REG_RES_CNT)
				res_cnt <= s_axi_lite_wdata;
			else if (res_fire)
				res_cnt <= res_cnt_inc;

			if (res_fire && itr_en && res_cnt_inc == itr_th)
				itr_pend <= 1'b1; // set beats clear
			else if (wr_en && s_axi_lite_awaddr == REG_STATUS && s_axi_lite_wdata[0])
				itr_pend <= 1'b0;
		end
	end

	assign itr = itr_pend;

	always_comb begin
		case (s_axi_lite_araddr)
			REG_CTRL: rd_mux = {30'd0, itr_en, act_en};
			REG_STATUS: rd_mux = {31'd0, itr_pend};
			REG_ACT_C: rd_mux = {{(32-`DATA_W){1'b0}}, act_rate_c};
			REG_ITR_TH: rd_mux = itr_th;
			REG_RES_CNT: rd_mux = res_cnt;
			default: rd_mux = 32'd0; // a/b windows read as zero
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			r_state <= AXIL_IDLE;
			s_axi_lite_rvalid <= 1'b0;
		end else begin
			case (r_state)
				AXIL_IDLE: begin
					if (s_axi_lite_arvalid) begin
						s_axi_lite_rvalid <= 1'b1;
						r_state <= AXIL_RESP;
					end
				end
				AXIL_RESP: begin
					if (s_axi_lite_rready) begin
						s_axi_lite_rvalid <= 1'b0;
						r_state <= AXIL_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (s_axi_lite_arvalid && s_axi_lite_arready)
			s_axi_lite_rdata <= rd_mux;
	end

	// response only after an accepted address and data beat
	a_b_after_aw: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(s_axi_lite_bvalid) |-> !s_axi_lite_awready &&
			$past(s_axi_lite_awready && s_axi_lite_awvalid && s_axi_lite_wvalid));

	a_par_in_win: assert property (@(posedge clk) disable iff (!rst_n)
		cfg.par_wen |-> $past(s_axi_lite_awaddr[`AXIL_AW-1:`CHN_W+2]) ==
			(cfg.par_sel == PAR_B ? REG_PAR_B_BASE : REG_PAR_A_BASE) >> (`CHN_W+2));
endmodule

/* hdl/conv_act_top.sv */
`timescale 1ns/10ps
`include "conv_act_cfg.svh"

module conv_act_top (
	input logic clk,
	input logic rst_n,

	input logic [`AXIL_AW-1:0] s_axi_lite_awaddr,
	input logic s_axi_lite_awvalid,
	output logic s_axi_lite_awready,
	input logic [31:0] s_axi_lite_wdata,
	input logic [3:0] s_axi_lite_wstrb,
	input logic s_axi_lite_wvalid,
	output logic s_axi_lite_wready,
	output logic [1:0] s_axi_lite_bresp,
	output logic s_axi_lite_bvalid,
	input logic s_axi_lite_bready,
	input logic [`AXIL_AW-1:0] s_axi_lite_araddr,
	input logic s_axi_lite_arvalid,
	output logic s_axi_lite_arready,
	output logic [31:0] s_axi_lite_rdata,
	output logic [1:0] s_axi_lite_rresp,
	output logic s_axi_lite_rvalid,
	input logic s_axi_lite_rready,

	input conv_act_pkg::data_t s_res_data,
	input conv_act_pkg::chn_t s_res_chn,
	input logic s_res_last,
	input logic s_res_valid,
	output logic s_res_ready,

	output conv_act_pkg::data_t m_act_data,
	output logic m_act_last,
	output logic m_act_valid,
	input logic m_act_ready,

	output logic itr
);
	logic res_fire; // one per output beat

	act_cfg_if cfg_if ();

	conv_act_regs regs_u (
		.clk(clk),
		.rst_n(rst_n),
		.s_axi_lite_awaddr(s_axi_lite_awaddr),
		.s_axi_lite_awvalid(s_axi_lite_awvalid),
		.s_axi_lite_awready(s_axi_lite_awready),
		.s_axi_lite_wdata(s_axi_lite_wdata),
		.s_axi_lite_wstrb(s_axi_lite_wstrb),
		.s_axi_lite_wvalid(s_axi_lite_wvalid),
		.s_axi_lite_wready(s_axi_lite_wready),
		.s_axi_lite_bresp(s_axi_lite_bresp),
		.s_axi_lite_bvalid(s_axi_lite_bvalid),
		.s_axi_lite_bready(s_axi_lite_bready),
		.s_axi_lite_araddr(s_axi_lite_araddr),
		.s_axi_lite_arvalid(s_axi_lite_arvalid),
		.s_axi_lite_arready(s_axi_lite_arready),
		.s_axi_lite_rdata(s_axi_lite_rdata),
		.s_axi_lite_rresp(s_axi_lite_rresp),
		.s_axi_lite_rvalid(s_axi_lite_rvalid),
		.s_axi_lite_rready(s_axi_lite_rready),
		.cfg(cfg_if.regs),
		.res_fire(res_fire),
		.itr(itr)
	);

	linear_act_cal cal_u (
		.clk(clk),
		.rst_n(rst_n),
		.cfg(cfg_if.cal),
		.s_res_data(s_res_data),
		.s_res_chn(s_res_chn),
		.s_res_last(s_res_last),
		.s_res_valid(s_res_valid),
		.s_res_ready(s_res_ready),
		.m_act_data(m_act_data),
		.m_act_last(m_act_last),
		.m_act_valid(m_act_valid),
		.m_act_ready(m_act_ready),
		.res_fire(res_fire)
	);
endmodule

/* hdl/linear_act_cal.sv */
`timescale 1ns/10ps
`include "conv_act_cfg.svh"

module linear_act_cal (
	input logic clk,
	input logic rst_n,

	act_cfg_if.cal cfg,

	input conv_act_pkg::data_t s_res_data,
	input conv_act_pkg::chn_t s_res_chn,
	input logic s_res_last,
	input logic s_res_valid,
	output logic s_res_ready,

	output conv_act_pkg::data_t m_act_data,
	output logic m_act_last,
	output logic m_act_valid,
	input logic m_act_ready,

	output logic res_fire
);
	import conv_act_pkg::*;

	data_t par_a [`CHN_N];
	data_t par_b [`CHN_N];

	logic pipe_en;
	logic v0, v1;
	logic last0, last1;
	data_t x0, a0, b0;
	data_t z1;
	logic signed [2*`DATA_W-1:0] prod_ax;
	logic signed [2*`DATA_W:0] lin_sum;
	logic signed [2*`DATA_W-1:0] prod_zc;
	logic signed [2*`DATA_W:0] act_neg;

	// clamp a wide signed value into DATA_W bits
	function automatic data_t sat_data(input logic signed [2*`DATA_W:0] v);
		data_t res;
		if (v[2*`DATA_W:`DATA_W-1] == '0 || v[2*`DATA_W:`DATA_W-1] == '1)
			res = v[`DATA_W-1:0];
		else if (v[2*`DATA_W])
			res = {1'b1, {(`DATA_W-1){1'b0}}};
		else
			res = {1'b0, {(`DATA_W-1){1'b1}}};
		return res;
	endfunction

	always_ff @(posedge clk) begin
		if (cfg.par_wen) begin
			case (cfg.par_sel)
				PAR_A: par_a[cfg.par_chn] <= cfg.par_data;
				PAR_B: par_b[cfg.par_chn] <= cfg.par_data;
			endcase
		end
	end

	// whole pipe moves or holds together
	assign pipe_en = !m_act_valid || m_act_ready;
	assign s_res_ready = pipe_en && cfg.act_en;
	assign res_fire = m_act_valid && m_act_ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			v0 <= 1'b0;
			v1 <= 1'b0;
			m_act_valid <= 1'b0;
		end else if (pipe_en) begin
			v0 <= s_res_valid && s_res_ready;
			v1 <= v0;
			m_act_valid <= v1;
		end
	end

	assign prod_ax = a0 * x0; // 22 fraction bits
	assign lin_sum = (prod_ax >>> `AB_FRAC) + b0;
	assign prod_zc = z1 * cfg.act_rate_c;
	assign act_neg = prod_zc >>> `C_FRAC;

	always_ff @(posedge clk) begin
		if (pipe_en) begin
			// stage 0 operand fetch
			x0 <= s_res_data;
			a0 <= par_a[s_res_chn];
			b0 <= par_b[s_res_chn];
			last0 <= s_res_last;
			// stage 1 a*x + b
			z1 <= sat_data(lin_sum);
			last1 <= last0;
			// stage 2 leaky relu
			m_act_data <= z1[`DATA_W-1] ? sat_data(act_neg) : z1;
			m_act_last <= last1;
		end
	end

	a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
		m_act_valid && !m_act_ready |=> m_act_valid && $stable(m_act_data));

	// nothing enters stage 0 while the unit is off
	a_off_no_ready: assert property (@(posedge clk) disable iff (!rst_n)
		!cfg.act_en && pipe_en |=> !v0);
endmodule

/* tb.f */
+incdir+hdl
hdl/conv_act_pkg.sv
hdl/act_cfg_if.sv
hdl/conv_act_regs.sv
hdl/linear_act_cal.sv
hdl/conv_act_top.sv
test/conv_act_tb.sv

/* test/conv_act_tb.sv */
`timescale 1ns/10ps
`include "conv_act_cfg.svh"

module conv_act_tb;
	import conv_act_pkg::*;

	localparam int N_ENT = 32;
	localparam int TMO = 50; // bus handshake limit in cycles
	localparam int RX_TMO = 200;

	typedef struct {
		data_t x;
		chn_t chn;
		logic last;
		data_t exp;
	} entry_t;

	logic clk, rst_n;
	logic [`AXIL_AW-1:0] s_axi_lite_awaddr, s_axi_lite_araddr;
	logic s_axi_lite_awvalid, s_axi_lite_wvalid, s_axi_lite_arvalid;
	logic s_axi_lite_bready, s_axi_lite_rready;
	logic s_axi_lite_awready, s_axi_lite_wready, s_axi_lite_bvalid;
	logic s_axi_lite_arready, s_axi_lite_rvalid;
	logic [31:0] s_axi_lite_wdata, s_axi_lite_rdata;
	logic [3:0] s_axi_lite_wstrb;
	logic [1:0] s_axi_lite_bresp, s_axi_lite_rresp;
	data_t s_res_data, m_act_data;
	chn_t s_res_chn;
	logic s_res_last, s_res_valid, s_res_ready;
	logic m_act_last, m_act_valid, m_act_ready;
	logic itr;

	entry_t tab [N_ENT];
	data_t a_tab [`CHN_N];
	data_t b_tab [`CHN_N];
	data_t c_val;
	logic [31:0] rng_state = 32'hb586c758;
	logic [31:0] rdy_state = 32'hb586c758; // own stream for back-pressure
	int err_cnt = 0;
	int tmo_cnt = 0;

	conv_act_top UUT (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] v;
		v = s;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	function automatic int rand_between(input int lo, input int hi);
		rng_state = xorshift32(rng_state);
		return lo + int'(rng_state % (hi - lo + 1));
	endfunction

	function automatic longint clamp_data(input longint v);
		longint hi;
		longint lo;
		hi = (longint'(1) <<< (`DATA_W - 1)) - 1;
		lo = -(longint'(1) <<< (`DATA_W - 1));
		if (v > hi)
			return hi;
		else if (v < lo)
			return lo;
		return v;
	endfunction

	// linear step then leaky relu on the negative side
	function automatic data_t expected_act(input data_t x, input data_t a, input data_t b,
			input data_t c);
		longint z;
		longint y;
		z = clamp_data(((longint'(a) * longint'(x)) >>> `AB_FRAC) + longint'(b));
		if (z < 0)
			y = clamp_data((z * longint'(c)) >>> `C_FRAC);
		else
			y = z;
		return data_t'(y);
	endfunction

	task automatic compare_data(input data_t got, input data_t exp, input string what);
		if (got !== exp) begin
			err_cnt++;
			$display("error at %0t: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic compare_reg(input logic [31:0] got, input logic [31:0] exp,
			input string what);
		if (got !== exp) begin
			err_cnt++;
			$display("error at %0t: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
		end
	endtask

	task automatic compare_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			err_cnt++;
			$display("error at %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic report_timeout(input string what);
		tmo_cnt++;
		$display("timeout at %0t while waiting for %s", $time, what);
	endtask

	// called at posedge+2, returns at posedge+2
	task automatic axil_write(input logic [`AXIL_AW-1:0] addr, input logic [31:0] data);
		int cyc;
		s_axi_lite_awaddr = addr;
		s_axi_lite_wdata = data;
		s_axi_lite_awvalid = 1'b1;
		s_axi_lite_wvalid = 1'b1;
		cyc = 0;
		do begin
			@(negedge clk);
			cyc++;
		end while (!(s_axi_lite_awready && s_axi_lite_wready) && cyc < TMO);
		if (!(s_axi_lite_awready && s_axi_lite_wready))
			report_timeout("write address and data ready");
		@(posedge clk);
		#2;
		s_axi_lite_awvalid = 1'b0;
		s_axi_lite_wvalid = 1'b0;
		cyc = 0;
		do begin
			@(negedge clk);
			cyc++;
		end while (!s_axi_lite_bvalid && cyc < TMO);
		if (!s_axi_lite_bvalid)
			report_timeout("write response");
		compare_reg({30'd0, s_axi_lite_bresp}, 32'd0, "bresp");
		@(posedge clk);
		#2;
	endtask

	task automatic axil_read(input logic [`AXIL_AW-1:0] addr, output logic [31:0] data);
		int cyc;
		s_axi_lite_araddr = addr;
		s_axi_lite_arvalid = 1'b1;
		cyc = 0;
		do begin
			@(negedge clk);
			cyc++;
		end while (!s_axi_lite_arready && cyc < TMO);
		if (!s_axi_lite_arready)
			report_timeout("read address ready");
		@(posedge clk);
		#2;
		s_axi_lite_arvalid = 1'b0;
		cyc = 0;
		do begin
			@(negedge clk);
			cyc++;
		end while (!s_axi_lite_rvalid && cyc < TMO);
		if (!s_axi_lite_rvalid)
			report_timeout("read data");
		data = s_axi_lite_rdata;
		compare_reg({30'd0, s_axi_lite_rresp}, 32'd0, "rresp");
		@(posedge clk);
		#2;
	endtask

	task automatic send_table();
		int cyc;
		for (int i = 0; i < N_ENT; i++) begin
			s_res_data = tab[i].x;
			s_res_chn = tab[i].chn;
			s_res_last = tab[i].last;
			s_res_valid = 1'b1;
			cyc = 0;
			do begin
				@(negedge clk);
				cyc++;
			end while (!s_res_ready && cyc < RX_TMO);
			if (!s_res_ready)
				report_timeout($sformatf("s_res_ready on entry %0d", i));
			@(posedge clk);
			#2;
		end
		s_res_valid = 1'b0;
	endtask

	// random back-pressure, outputs matched in table order
	task automatic receive_outputs();
		int idx;
		int idle;
		idx = 0;
		idle = 0;
		while (idx < N_ENT && idle < RX_TMO) begin
			@(posedge clk);
			#2;
			rdy_state = xorshift32(rdy_state);
			m_act_ready = (rdy_state[3:0] > 4'd4);
			@(negedge clk);
			if (m_act_valid && m_act_ready) begin
				compare_data(m_act_data, tab[idx].exp, $sformatf("output %0d", idx));
				compare_bit(m_act_last, tab[idx].last, $sformatf("last of output %0d", idx));
				compare_bit(itr, 1'b0, "itr before threshold");
				idx++;
				idle = 0;
			end else begin
				idle++;
			end
		end
		if (idx < N_ENT)
			report_timeout($sformatf("output %0d", idx));
		@(posedge clk);
		#2;
		m_act_ready = 1'b1;
	endtask

	initial begin
		logic [31:0] rd;
		s_axi_lite_awaddr = '0;
		s_axi_lite_araddr = '0;
		s_axi_lite_awvalid = 1'b0;
		s_axi_lite_wvalid = 1'b0;
		s_axi_lite_arvalid = 1'b0;
		s_axi_lite_wdata = '0;
		s_axi_lite_wstrb = 4'hf;
		s_axi_lite_bready = 1'b1;
		s_axi_lite_rready = 1'b1;
		s_res_data = '0;
		s_res_chn = '0;
		s_res_last = 1'b0;
		s_res_valid = 1'b0;
		m_act_ready = 1'b0;
		rst_n = 1'b0;

		// a up to +-2.0, b up to +-1.0, slope 0 to 0.5
		for (int ch = 0; ch < `CHN_N; ch++) begin
			a_tab[ch] = data_t'(rand_between(-8192, 8191));
			b_tab[ch] = data_t'(rand_between(-1024, 1023));
		end
		a_tab[`CHN_N-1] = 16'sh7fff; // overflow channel
		c_val = data_t'(rand_between(0, 8191));
		for (int i = 0; i < N_ENT; i++) begin
			tab[i].x = data_t'(rand_between(-4096, 4095));
			tab[i].chn = chn_t'(rand_between(0, `CHN_N - 1));
			tab[i].last = (i % 8 == 7);
		end
		tab[N_ENT-2].x = 16'sd32000;
		tab[N_ENT-2].chn = chn_t'(`CHN_N - 1);
		tab[N_ENT-1].x = -16'sd32000;
		tab[N_ENT-1].chn = chn_t'(`CHN_N - 1);
		for (int i = 0; i < N_ENT; i++)
			tab[i].exp = expected_act(tab[i].x, a_tab[tab[i].chn], b_tab[tab[i].chn], c_val);

		repeat (2) @(posedge clk);
		#2;
		rst_n = 1'b1;

		axil_write(REG_CTRL, 32'h2); // itr_en only, stream still off
		axil_read(REG_CTRL, rd);
		compare_reg(rd, 32'h2, "REG_CTRL readback");
		axil_write(REG_ACT_C, 32'(c_val));
		axil_read(REG_ACT_C, rd);
		compare_reg(rd, 32'(c_val), "REG_ACT_C readback");
		axil_write(REG_ITR_TH, N_ENT);
		axil_read(REG_ITR_TH, rd);
		compare_reg(rd, N_ENT, "REG_ITR_TH readback");
		for (int ch = 0; ch < `CHN_N; ch++) begin
			axil_write(REG_PAR_A_BASE + 4 * ch, 32'(a_tab[ch]));
			axil_write(REG_PAR_B_BASE + 4 * ch, 32'(b_tab[ch]));
		end
		axil_read(REG_PAR_A_BASE + 4 * 5, rd);
		compare_reg(rd, 32'd0, "parameter a read");
		axil_read(REG_PAR_B_BASE + 4 * 9, rd);
		compare_reg(rd, 32'd0, "parameter b read");

		// unit disabled, first entry offered but must not move
		s_res_data = tab[0].x;
		s_res_chn = tab[0].chn;
		s_res_last = tab[0].last;
		s_res_valid = 1'b1;
		m_act_ready = 1'b1;
		repeat (20) begin
			@(negedge clk);
			compare_bit(s_res_ready, 1'b0, "s_res_ready while disabled");
			compare_bit(m_act_valid, 1'b0, "m_act_valid while disabled");
		end
		@(posedge clk);
		#2;
		s_res_valid = 1'b0; // withdrawn so the enable write takes no beat
		axil_write(REG_CTRL, 32'h3);

		fork
			send_table();
			receive_outputs();
		join

		@(negedge clk);
		compare_bit(itr, 1'b1, "itr at threshold");
		compare_bit(m_act_valid, 1'b0, "extra output after table");
		@(posedge clk);
		#2;
		axil_read(REG_RES_CNT, rd);
		compare_reg(rd, N_ENT, "REG_RES_CNT");
		axil_write(REG_STATUS, 32'h1);
		@(negedge clk);
		compare_bit(itr, 1'b0, "itr after clear");
		@(posedge clk);
		#2;
		axil_read(REG_STATUS, rd);
		compare_reg(rd, 32'd0, "REG_STATUS after clear");

		$display("failed checks: %0d, timeouts: %0d", err_cnt, tmo_cnt);
		if (err_cnt == 0 && tmo_cnt == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end
endmodule
